//--- addr_pkg.sv
package addr_pkg;

	localparam int ADDR_W    = 16;  // Address bus width
	localparam int NUM_PAIRS = 5;   // BC DE HL SP PC
	localparam int DMA_LEN   = 160; // Sprite table bytes per DMA run

	// Pointer pair select
	typedef enum logic [2:0] {
		BC = 3'd0,
		DE = 3'd1,
		HL = 3'd2,
		SP = 3'd3,
		PC = 3'd4
	} pair_id_e;

	// IDU control
	typedef struct packed {
		logic pair; // Low byte carry runs into high byte
		logic dec;  // Count down
		logic inc;  // Count up
	} idu_op_t;     // inc and dec both low means pass-through

	// Byte view of a pointer pair
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} pair_bytes_t;

	// One pair value seen as a word or as two bytes
	typedef union packed {
		logic [ADDR_W-1:0] word;  // Pair mode and loads
		pair_bytes_t       bytes; // Split mode
	} pair_val_u;

	// One CPU address-side command, 24 bits
	typedef struct packed {
		logic        valid;
		pair_id_e    sel;   // Pair to drive onto the bus
		idu_op_t     op;
		logic        wb;    // Write IDU result back into the pair
		logic        rd;    // Bus read strobe
		logic        wr;    // Bus write strobe
		logic        ld;    // Load pair from load_val
		logic [12:0] spare; // Zero
	} cpu_cmd_t;

	// Bus request from CPU or DMA, also the registered bus
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              rd;
		logic              wr;
	} bus_req_t;

endpackage

//--- idu.sv
module idu (
	input  addr_pkg::pair_val_u val,
	input  addr_pkg::idu_op_t   op,
	output addr_pkg::pair_val_u result
);

	logic [addr_pkg::ADDR_W-1:0] prop;    // Bit passes a carry upward
	logic [addr_pkg::ADDR_W-1:0] tog;     // Bit flips
	logic                        lo_cout; // Carry out of the low byte

	// Propagate term per bit
	always_comb begin
		for (int i = 0; i < addr_pkg::ADDR_W; i++) begin
			if (op.inc) begin
				prop[i] = val.word[i];      // Ones pass an increment
			end else begin
				prop[i] = op.dec & ~val.word[i]; // Zeros pass a borrow
			end
		end
	end

	// Toggle chain
	// Bit 0 flips on any count, higher bits flip when every lower bit in the group propagates
	always_comb begin
		tog[0] = op.inc | op.dec;
		for (int i = 1; i < 8; i++) begin
			tog[i] = tog[i-1] & prop[i-1];
		end
		lo_cout = tog[7] & prop[7];
		tog[8]  = op.pair & lo_cout;    // Chain broken at bit 8 in split mode
		for (int i = 9; i < addr_pkg::ADDR_W; i++) begin
			tog[i] = tog[i-1] & prop[i-1];
		end
	end

	// Result assembly
	always_comb begin
		result = val;
		if (op.pair) begin
			result.word = val.word ^ tog;           // Full 16-bit count
		end else begin
			result.bytes.lo = val.bytes.lo ^ tog[7:0]; // Low byte wraps on its own
			result.bytes.hi = val.bytes.hi;         // High byte untouched
		end
	end

	// Only one count direction per command
	always_comb begin
		assert (!(op.inc && op.dec))
			else $error("idu: inc and dec set together");
	end

endmodule

//--- pointer_regs.sv
module pointer_regs (
	input  logic                CLK4,
	input  logic                rst_n,
	input  addr_pkg::cpu_cmd_t  cmd,
	input  logic                stall,    // DMA owns the bus
	input  addr_pkg::pair_val_u load_val,
	input  addr_pkg::pair_val_u wb_val,   // IDU result
	output addr_pkg::pair_val_u pair_out
);

	addr_pkg::pair_val_u regs [addr_pkg::NUM_PAIRS]; // BC DE HL SP PC
	logic                sel_ok; // Select names a real pair
	logic                do_ld;
	logic                do_wb;

	assign sel_ok = (int'(cmd.sel) < addr_pkg::NUM_PAIRS);

	// Read port, combinational
	assign pair_out = sel_ok ? regs[cmd.sel] : '0;

	// Load ignores the stall since it never touches the bus
	assign do_ld = cmd.valid & cmd.ld & sel_ok;
	// Write-back dropped under stall, load wins over it
	assign do_wb = cmd.valid & cmd.wb & ~cmd.ld & ~stall & sel_ok;

	always_ff @(posedge CLK4 or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < addr_pkg::NUM_PAIRS; i++) begin
				regs[i] <= '0;
			end
		end else if (do_ld) begin
			regs[cmd.sel].word <= load_val.word; // Load by word
		end else if (do_wb) begin
			regs[cmd.sel] <= wb_val;             // Same edge as the bus request
		end
	end

	// Pair select from the CPU side stays in range
	a_sel_range: assert property (@(posedge CLK4) disable iff (!rst_n)
		cmd.valid |-> sel_ok)
		else $error("pointer_regs: pair select out of range");

endmodule

//--- sprite_dma.sv
module sprite_dma (
	input  logic               CLK4,
	input  logic               rst_n,
	input  logic               start,   // One-cycle pulse
	input  logic [7:0]         src_hi,  // Source page
	output addr_pkg::bus_req_t dma_bus,
	output logic               busy
);

	logic [7:0] src_q; // Latched source page
	logic [7:0] idx;   // Byte within the page
	logic       busy_q;
	logic       last;  // Final transfer this cycle
	logic       go;    // Accepted start

	assign last = busy_q && (idx == 8'(addr_pkg::DMA_LEN - 1));
	assign go   = start & ~busy_q; // Start while busy is dropped

	// Run control
	always_ff @(posedge CLK4 or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			idx    <= '0;
		end else if (go) begin
			busy_q <= 1'b1;
			idx    <= '0;
		end else if (last) begin
			busy_q <= 1'b0; // Falls after DMA_LEN busy cycles
			idx    <= '0;
		end else if (busy_q) begin
			idx <= idx + 8'd1;
		end
	end

	// Source page, payload only
	always_ff @(posedge CLK4) begin
		if (go) begin
			src_q <= src_hi;
		end
	end

	assign busy         = busy_q;
	assign dma_bus.addr = {src_q, idx}; // Page plus index
	assign dma_bus.rd   = busy_q;       // Reads only
	assign dma_bus.wr   = 1'b0;

	// Index stays inside the sprite table for the whole run
	a_idx_range: assert property (@(posedge CLK4) disable iff (!rst_n)
		busy |-> (int'(idx) < addr_pkg::DMA_LEN))
		else $error("sprite_dma: index past end of table");

endmodule

//--- bus_arbiter.sv
module bus_arbiter (
	input  logic               CLK4,
	input  logic               rst_n,
	input  logic               cpu_valid,
	input  addr_pkg::bus_req_t cpu_bus,
	input  logic               dma_busy,
	input  addr_pkg::bus_req_t dma_bus,
	output logic               cpu_stall,
	output addr_pkg::bus_req_t bus_out
);

	logic dma_grant;
	logic cpu_grant;

	assign dma_grant = dma_busy;              // DMA always first
	assign cpu_grant = cpu_valid & ~dma_busy;
	assign cpu_stall = dma_busy;              // CPU held off as a level

	// Registered bus one cycle after the grant
	always_ff @(posedge CLK4 or negedge rst_n) begin
		if (!rst_n) begin
			bus_out <= '0;
		end else if (dma_grant) begin
			bus_out <= dma_bus;
		end else if (cpu_grant) begin
			bus_out <= cpu_bus;
		end else begin
			bus_out.rd <= 1'b0; // Idle bus
			bus_out.wr <= 1'b0; // Address kept like a bus keeper
		end
	end

	// DMA strobes only while it holds the bus
	a_dma_owner: assert property (@(posedge CLK4) disable iff (!rst_n)
		(dma_bus.rd || dma_bus.wr) |-> dma_busy)
		else $error("bus_arbiter: DMA request outside its bus ownership");

endmodule

//--- addr_unit_top.sv
module addr_unit_top (
	input  logic                CLK4,
	input  logic                rst_n,
	input  addr_pkg::cpu_cmd_t  cpu_cmd,
	input  addr_pkg::pair_val_u load_val,
	input  logic                dma_start,
	input  logic [7:0]          dma_src_hi,
	output logic                cpu_stall,
	output logic                dma_busy,
	output addr_pkg::bus_req_t  bus_out
);

	addr_pkg::pair_val_u pair_out;   // Selected pair
	addr_pkg::pair_val_u idu_result; // IDU output, written back
	addr_pkg::bus_req_t  cpu_bus;    // CPU request to the arbiter
	addr_pkg::bus_req_t  dma_bus;    // DMA request to the arbiter

	// CPU request is the pair value plus strobes
	assign cpu_bus.addr = pair_out.word;
	assign cpu_bus.rd   = cpu_cmd.rd;
	assign cpu_bus.wr   = cpu_cmd.wr;

	pointer_regs u_regs (
		.CLK4     (CLK4),
		.rst_n    (rst_n),
		.cmd      (cpu_cmd),
		.stall    (cpu_stall),
		.load_val (load_val),
		.wb_val   (idu_result),
		.pair_out (pair_out)
	);

	idu u_idu (
		.val    (pair_out),
		.op     (cpu_cmd.op),
		.result (idu_result)
	);

	sprite_dma u_dma (
		.CLK4    (CLK4),
		.rst_n   (rst_n),
		.start   (dma_start),
		.src_hi  (dma_src_hi),
		.dma_bus (dma_bus),
		.busy    (dma_busy)
	);

	bus_arbiter u_arb (
		.CLK4      (CLK4),
		.rst_n     (rst_n),
		.cpu_valid (cpu_cmd.valid),
		.cpu_bus   (cpu_bus),
		.dma_busy  (dma_busy),
		.dma_bus   (dma_bus),
		.cpu_stall (cpu_stall),
		.bus_out   (bus_out)
	);

endmodule

//--- tb_addr_unit.sv
module tb_addr_unit;
	timeunit 1ns;
	timeprecision 1ps;

	logic                CLK4;
	logic                rst_n;
	addr_pkg::cpu_cmd_t  cpu_cmd;
	addr_pkg::pair_val_u load_val;
	logic                dma_start;
	logic [7:0]          dma_src_hi;
	logic                cpu_stall;
	logic                dma_busy;
	addr_pkg::bus_req_t  bus_out;

	int seed = 80297; // Fixed seed for the random start value

	addr_unit_top u_dut (
		.CLK4       (CLK4),
		.rst_n      (rst_n),
		.cpu_cmd    (cpu_cmd),
		.load_val   (load_val),
		.dma_start  (dma_start),
		.dma_src_hi (dma_src_hi),
		.cpu_stall  (cpu_stall),
		.dma_busy   (dma_busy),
		.bus_out    (bus_out)
	);

	always #50 CLK4 = ~CLK4; // 100 ns period

	// Rising edge plus input skew
	task automatic next_cycle();
		@(posedge CLK4);
		#1;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout at t=%0t while waiting for %s", $time, what);
		$display("sim failed");
		$fatal(1, "stopped on timeout");
	endtask

	function automatic addr_pkg::idu_op_t make_op(input logic pair, input logic dec, input logic inc);
		addr_pkg::idu_op_t op;
		op.pair = pair;
		op.dec  = dec;
		op.inc  = inc;
		return op;
	endfunction

	// Expected IDU output as word or low-byte count
	function automatic logic [15:0] expect_idu(input logic [15:0] v, input addr_pkg::idu_op_t op);
		logic [15:0] r;
		if (op.inc) begin
			r = op.pair ? v + 16'd1 : {v[15:8], v[7:0] + 8'd1};
		end else if (op.dec) begin
			r = op.pair ? v - 16'd1 : {v[15:8], v[7:0] - 8'd1};
		end else begin
			r = v; // Pass-through
		end
		return r;
	endfunction

	task automatic drive_cmd(input addr_pkg::pair_id_e sel, input addr_pkg::idu_op_t op,
			input logic wb, input logic rd, input logic ld);
		cpu_cmd       = '0;
		cpu_cmd.valid = 1'b1;
		cpu_cmd.sel   = sel;
		cpu_cmd.op    = op;
		cpu_cmd.wb    = wb;
		cpu_cmd.rd    = rd;
		cpu_cmd.ld    = ld;
	endtask

	task automatic load_pair(input addr_pkg::pair_id_e sel, input logic [15:0] val);
		load_val.word = val;
		drive_cmd(sel, make_op(1'b0, 1'b0, 1'b0), 1'b0, 1'b0, 1'b1);
		next_cycle();
		cpu_cmd = '0;
	endtask

	// Plain bus read shows the pair value one cycle later
	task automatic read_pair(input addr_pkg::pair_id_e sel, input logic [15:0] exp);
		drive_cmd(sel, make_op(1'b0, 1'b0, 1'b0), 1'b0, 1'b1, 1'b0);
		next_cycle();
		check_val("bus_out.addr", 32'(exp), 32'(bus_out.addr));
		check_val("bus_out.rd", 32'(1), 32'(bus_out.rd));
		cpu_cmd = '0;
	endtask

	// Load, one IDU command with write-back, then read back
	task automatic run_op(input addr_pkg::pair_id_e sel, input logic [15:0] val,
			input addr_pkg::idu_op_t op);
		load_pair(sel, val);
		drive_cmd(sel, op, 1'b1, 1'b1, 1'b0);
		next_cycle();
		check_val("bus_out.addr", 32'(val), 32'(bus_out.addr)); // Old value on the bus
		check_val("bus_out.rd", 32'(1), 32'(bus_out.rd));
		check_val("bus_out.wr", 32'(0), 32'(bus_out.wr));
		cpu_cmd = '0;
		read_pair(sel, expect_idu(val, op));
	endtask

	// Full DMA run with an optional CPU command pushed into the stall
	task automatic run_dma(input logic [7:0] src, input logic hold_cpu);
		int n;
		dma_src_hi = src;
		dma_start  = 1'b1;
		next_cycle();
		dma_start  = 1'b0;
		check_val("dma_busy", 32'(1), 32'(dma_busy)); // Rises at the edge after start
		n = 0;
		while (dma_busy === 1'b1) begin
			if (n > addr_pkg::DMA_LEN) begin
				timeout_abort("end of sprite DMA");
			end else begin
				if (hold_cpu && n < 4) begin
					drive_cmd(addr_pkg::BC, make_op(1'b1, 1'b0, 1'b1), 1'b1, 1'b1, 1'b0);
					check_val("cpu_stall", 32'(1), 32'(cpu_stall));
				end else begin
					cpu_cmd = '0;
				end
				next_cycle();
				check_val("bus_out.addr", 32'({src, n[7:0]}), 32'(bus_out.addr));
				check_val("bus_out.rd", 32'(1), 32'(bus_out.rd));
				n++;
			end
		end
		cpu_cmd = '0;
		check_val("dma busy cycles", 32'(addr_pkg::DMA_LEN), 32'(n));
		check_val("cpu_stall", 32'(0), 32'(cpu_stall)); // Released with busy
	endtask

	task automatic test_reset();
		check_val("bus_out", 32'(0), 32'(bus_out));
		check_val("cpu_stall", 32'(0), 32'(cpu_stall));
		check_val("dma_busy", 32'(0), 32'(dma_busy));
	endtask

	task automatic test_pair_inc();
		logic [15:0] rnd;
		run_op(addr_pkg::PC, 16'h12FF, make_op(1'b1, 1'b0, 1'b1)); // Carry into high byte
		rnd = 16'($random(seed));
		run_op(addr_pkg::PC, rnd, make_op(1'b1, 1'b0, 1'b1));
	endtask

	task automatic test_pair_dec();
		run_op(addr_pkg::SP, 16'h0000, make_op(1'b1, 1'b1, 1'b0)); // Wraps to FFFF
	endtask

	task automatic test_split();
		run_op(addr_pkg::HL, 16'h12FF, make_op(1'b0, 1'b0, 1'b1)); // Low byte wraps alone
		run_op(addr_pkg::DE, 16'h3400, make_op(1'b0, 1'b1, 1'b0));
		run_op(addr_pkg::BC, 16'hBEEF, make_op(1'b0, 1'b0, 1'b0)); // Pass-through
	endtask

	task automatic test_dma();
		run_dma(8'hC1, 1'b0);
	endtask

	task automatic test_stall();
		load_pair(addr_pkg::BC, 16'h5A5A);
		run_dma(8'h80, 1'b1);
		read_pair(addr_pkg::BC, 16'h5A5A); // Dropped increment left no trace
	endtask

	initial begin
		CLK4       = 1'b0;
		rst_n      = 1'b0;
		cpu_cmd    = '0;
		load_val   = '0;
		dma_start  = 1'b0;
		dma_src_hi = 8'h00;
		repeat (2) @(posedge CLK4);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_pair_inc();
		test_pair_dec();
		test_split();
		test_dma();
		test_stall();
		$display("sim passed");
		$finish;
	end

endmodule

//--- filelist.f
addr_pkg.sv
idu.sv
pointer_regs.sv
sprite_dma.sv
bus_arbiter.sv
addr_unit_top.sv
tb_addr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the address unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_addr_unit_sim

verilator --binary --timing --assert -j 0 --top-module tb_addr_unit -f filelist.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
	echo "Result: FAIL"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "Result: PASS"
exit 0
